//--- cplx_mac.sv
`timescale 1ns/1ps
`include "tri_inv_defines.svh"

module cplx_mac import tri_inv_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clr_i,
  input  logic  acc_en_i,
  input  cplx_t a_i,
  input  cplx_t b_i,
  input  cplx_t scale_i,
  output cplx_t acc_o,
  output cplx_t neg_scaled_o
);

  cplx_t acc_q;
  cplx_t prod;
  cplx_t scaled;

  // full product shifted arithmetically right by the fraction width
  function automatic fxp_t fx_mul(fxp_t x, fxp_t y);
    logic signed [2*`TI_W-1:0] p;
    p = x * y;
    return p[`TI_FRAC +: `TI_W];
  endfunction

  function automatic cplx_t cx_mul(cplx_t x, cplx_t y);
    cplx_t r;
    r.re = fx_mul(x.re, y.re) - fx_mul(x.im, y.im);
    r.im = fx_mul(x.re, y.im) + fx_mul(x.im, y.re);
    return r;
  endfunction

  assign prod   = cx_mul(a_i, b_i);
  assign scaled = cx_mul(scale_i, acc_q);

  assign neg_scaled_o.re = -scaled.re;
  assign neg_scaled_o.im = -scaled.im;
  assign acc_o           = acc_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni || clr_i) begin
      acc_q <= '0;
    end else if (acc_en_i) begin
      acc_q.re <= acc_q.re + prod.re;
      acc_q.im <= acc_q.im + prod.im;
    end
  end

endmodule

//--- cplx_recip.sv
`timescale 1ns/1ps
`include "tri_inv_defines.svh"

module cplx_recip import tri_inv_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  flush_i,
  input  logic  in_valid_i,
  output logic  in_ready_o,
  input  cplx_t x_i,
  output logic  out_valid_o,
  input  logic  out_ready_i,
  output cplx_t y_o
);

  recip_op_e                 op_q;
  logic                      busy_q;
  logic                      start_q;
  logic                      out_valid_q;
  cplx_t                     x_q;
  cplx_t                     y_q;
  fxp_t                      norm_q;
  fxp_t                      re_q;
  logic signed [2*`TI_W-1:0] sq_sum;
  logic signed [2*`TI_W-1:0] re_ext;
  logic signed [2*`TI_W-1:0] im_ext;
  logic signed [2*`TI_W-1:0] div_num;
  logic                      launch_im;
  logic                      div_in_valid;
  logic                      div_in_ready;
  logic                      div_out_valid;
  fxp_t                      div_quot;
  logic                      accept;

  assign in_ready_o  = ~busy_q & ~out_valid_q;
  assign accept      = in_valid_i & in_ready_o;
  assign out_valid_o = out_valid_q;
  assign y_o         = y_q;

  assign sq_sum = x_i.re * x_i.re + x_i.im * x_i.im;
  assign re_ext = x_q.re;
  assign im_ext = x_q.im;

  // the imaginary pass starts on the same edge the real quotient is taken
  assign launch_im    = busy_q & div_out_valid & (op_q == DIV_RE);
  assign div_in_valid = start_q | launch_im;
  assign div_num      = ((op_q == DIV_IM) || div_out_valid) ? ((-im_ext) <<< `TI_FRAC)
                                                            : (re_ext <<< `TI_FRAC);

  always_ff @(posedge clk_i) begin
    if (!rst_ni || flush_i) begin
      busy_q      <= 1'b0;
      start_q     <= 1'b0;
      out_valid_q <= 1'b0;
      op_q        <= DIV_RE;
    end else begin
      if (accept) begin
        busy_q  <= 1'b1;
        start_q <= 1'b1;
        op_q    <= DIV_RE;
      end
      if (start_q && div_in_ready) begin
        start_q <= 1'b0;
      end
      if (busy_q && div_out_valid) begin
        if (op_q == DIV_RE) begin
          op_q <= DIV_IM;
        end else begin
          op_q        <= DIV_RE;
          busy_q      <= 1'b0;
          out_valid_q <= 1'b1;
        end
      end
      if (out_valid_q && out_ready_i) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      x_q    <= x_i;
      norm_q <= sq_sum[`TI_FRAC +: `TI_W];
    end
    if (busy_q && div_out_valid) begin
      if (op_q == DIV_RE) begin
        re_q <= div_quot;
      end else begin
        y_q.re <= re_q;
        y_q.im <= div_quot;
      end
    end
  end

  fxp_div u_div (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .in_valid_i  (div_in_valid),
    .in_ready_o  (div_in_ready),
    .num_i       (div_num),
    .den_i       (norm_q),
    .out_valid_o (div_out_valid),
    .out_ready_i (busy_q),
    .quot_o      (div_quot)
  );

  assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    out_valid_o && !out_ready_i |=> $stable(y_o));

endmodule

//--- fxp_div.sv
`timescale 1ns/1ps
`include "tri_inv_defines.svh"

module fxp_div import tri_inv_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  logic signed [2*`TI_W-1:0] num_i,
  input  fxp_t                      den_i,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output fxp_t                      quot_o
);

  localparam int CW = $clog2(`TI_W + 1);

  logic                 run_q;
  logic                 done_q;
  logic                 neg_q;
  logic [CW-1:0]        cnt_q;
  logic [`TI_W:0]       rem_q;
  logic [`TI_W-1:0]     den_q;
  // dividend bits leave at the top, quotient bits enter at the bottom
  logic [`TI_W-1:0]     dq_q;
  logic [2*`TI_W-1:0]   num_mag;
  logic [`TI_W-1:0]     den_mag;
  logic [`TI_W+1:0]     shifted;
  logic [`TI_W+1:0]     trial;
  logic                 accept;

  assign num_mag = num_i[2*`TI_W-1] ? -num_i : num_i;
  assign den_mag = den_i[`TI_W-1] ? -den_i : den_i;

  assign in_ready_o  = ~run_q & (~done_q | out_ready_i);
  assign accept      = in_valid_i & in_ready_o;
  assign out_valid_o = done_q;

  assign shifted = {rem_q, dq_q[`TI_W-1]};
  assign trial   = shifted - {2'b00, den_q};

  always_ff @(posedge clk_i) begin
    if (!rst_ni || flush_i) begin
      run_q  <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (accept) begin
      run_q  <= 1'b1;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (run_q) begin
      cnt_q <= cnt_q + 1'b1;
      if (cnt_q == CW'(`TI_W - 1)) begin
        run_q  <= 1'b0;
        done_q <= 1'b1;
      end
    end else if (done_q && out_ready_i) begin
      done_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rem_q <= {1'b0, num_mag[2*`TI_W-1:`TI_W]};
      dq_q  <= num_mag[`TI_W-1:0];
      den_q <= den_mag;
      neg_q <= num_i[2*`TI_W-1] ^ den_i[`TI_W-1];
    end else if (run_q) begin
      // restore when the trial subtraction borrows
      if (trial[`TI_W+1]) begin
        rem_q <= shifted[`TI_W:0];
      end else begin
        rem_q <= trial[`TI_W:0];
      end
      dq_q <= {dq_q[`TI_W-2:0], ~trial[`TI_W+1]};
    end
  end

  // sign applied to the magnitude, so the quotient truncates toward zero
  assign quot_o = neg_q ? -dq_q : dq_q;

  // the reciprocal unit only offers work when this divider can take it
  assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    in_valid_i && !out_valid_o |-> in_ready_o);

endmodule

//--- row_store.sv
`timescale 1ns/1ps
`include "tri_inv_defines.svh"

module row_store import tri_inv_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 busy_i,
  input  logic                 wr_valid_i,
  output logic                 wr_ready_o,
  input  logic [`TI_AW-1:0]    wr_addr_i,
  input  cplx_t [`TI_SIZE-1:0] wr_row_i,
  input  logic                 rd_valid_i,
  input  logic [`TI_AW-1:0]    rd_addr_i,
  output logic                 rd_row_valid_o,
  output cplx_t [`TI_SIZE-1:0] rd_row_o
);

  cplx_t [`TI_SIZE-1:0] mem_q [`TI_SIZE];

  // rows are frozen while an inversion runs
  assign wr_ready_o = ~busy_i;

  always_ff @(posedge clk_i) begin
    if (wr_valid_i && wr_ready_o) begin
      mem_q[wr_addr_i] <= wr_row_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_valid_i) begin
      rd_row_o <= mem_q[rd_addr_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rd_row_valid_o <= 1'b0;
    end else begin
      rd_row_valid_o <= rd_valid_i;
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# compile and run the triangular inverse testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f tri_inv.f --top-module tb_tri_inv > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_tri_inv > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" "$SIM_LOG"; then
  exit 1
fi
exit 0

//--- tb_tri_inv.sv
`timescale 1ns/1ps
`include "tri_inv_defines.svh"

module tb_tri_inv import tri_inv_pkg::*; ();

  localparam int WR_TMO   = 20;
  localparam int BUSY_TMO = 20;
  localparam int COL_TMO  = 2000;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  logic                 wr_valid_i;
  logic                 wr_ready_o;
  logic [`TI_AW-1:0]    wr_addr_i;
  cplx_t [`TI_SIZE-1:0] wr_row_i;
  logic                 start_i;
  logic                 flush_i;
  logic                 busy_o;
  logic                 col_valid_o;
  logic                 col_ready_i;
  logic [`TI_AW-1:0]    col_idx_o;
  cplx_t [`TI_SIZE-1:0] col_o;

  int errors   = 0;
  int timeouts = 0;
  int checks   = 0;

  // matrix under test and the expected inverse
  int l_re [`TI_SIZE][`TI_SIZE];
  int l_im [`TI_SIZE][`TI_SIZE];
  int x_re [`TI_SIZE][`TI_SIZE];
  int x_im [`TI_SIZE][`TI_SIZE];

  always #10 clk_i = ~clk_i;

  tri_inv_top u_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wr_valid_i  (wr_valid_i),
    .wr_ready_o  (wr_ready_o),
    .wr_addr_i   (wr_addr_i),
    .wr_row_i    (wr_row_i),
    .start_i     (start_i),
    .flush_i     (flush_i),
    .busy_o      (busy_o),
    .col_valid_o (col_valid_o),
    .col_ready_i (col_ready_i),
    .col_idx_o   (col_idx_o),
    .col_o       (col_o)
  );

  task automatic check_val(input string name, input logic [63:0] exp_v,
                           input logic [63:0] act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("ERR %s expected %h got %h", name, exp_v, act_v);
    end
  endtask

  // floor of the full product scaled down by the fraction width
  function automatic int mul_part(int x, int y);
    longint p;
    p = longint'(x) * longint'(y);
    return int'(p >>> `TI_FRAC);
  endfunction

  task automatic cmul(input int ar, input int ai, input int br, input int bi,
                      output int pr, output int pi);
    pr = mul_part(ar, br) - mul_part(ai, bi);
    pi = mul_part(ar, bi) + mul_part(ai, br);
  endtask

  task automatic recip_model(input int a, input int b, output int yr, output int yi);
    longint n;
    n  = (longint'(a) * a + longint'(b) * b) >>> `TI_FRAC;
    yr = int'((longint'(a) <<< `TI_FRAC) / n);
    yi = int'((-longint'(b) <<< `TI_FRAC) / n);
  endtask

  task automatic compute_inverse();
    int rr [`TI_SIZE];
    int ri [`TI_SIZE];
    int sr;
    int si;
    int pr;
    int pi;
    for (int i = 0; i < `TI_SIZE; i++) begin
      recip_model(l_re[i][i], l_im[i][i], rr[i], ri[i]);
    end
    for (int j = 0; j < `TI_SIZE; j++) begin
      for (int i = 0; i < `TI_SIZE; i++) begin
        x_re[i][j] = 0;
        x_im[i][j] = 0;
      end
      x_re[j][j] = rr[j];
      x_im[j][j] = ri[j];
      // forward substitution down column j
      for (int i = j + 1; i < `TI_SIZE; i++) begin
        sr = 0;
        si = 0;
        for (int k = j; k < i; k++) begin
          cmul(l_re[i][k], l_im[i][k], x_re[k][j], x_im[k][j], pr, pi);
          sr += pr;
          si += pi;
        end
        cmul(rr[i], ri[i], sr, si, pr, pi);
        x_re[i][j] = -pr;
        x_im[i][j] = -pi;
      end
    end
  endtask

  function automatic int signed_part(int unsigned mag);
    int v;
    v = int'($urandom % mag);
    return ($urandom % 2) ? -v : v;
  endfunction

  task automatic gen_matrix(input bit full);
    int v;
    for (int r = 0; r < `TI_SIZE; r++) begin
      for (int c = 0; c < `TI_SIZE; c++) begin
        if (r == c) begin
          v = 32'h10000 + int'($urandom % 32'h6000);
          l_re[r][c] = ($urandom % 2) ? -v : v;
          l_im[r][c] = signed_part(32'h10000);
        end else if (!full) begin
          l_re[r][c] = 0;
          l_im[r][c] = 0;
        end else if (r > c) begin
          l_re[r][c] = signed_part(32'h8000);
          l_im[r][c] = signed_part(32'h8000);
        end else begin
          // entries above the diagonal are ignored by the core
          l_re[r][c] = $urandom();
          l_im[r][c] = $urandom();
        end
      end
    end
  endtask

  task automatic write_row(input int r);
    int t;
    @(posedge clk_i);
    #1;
    wr_valid_i = 1'b1;
    wr_addr_i  = `TI_AW'(r);
    for (int c = 0; c < `TI_SIZE; c++) begin
      wr_row_i[c].re = l_re[r][c];
      wr_row_i[c].im = l_im[r][c];
    end
    t = 0;
    @(negedge clk_i);
    while (!wr_ready_o && t < WR_TMO) begin
      @(negedge clk_i);
      t++;
    end
    if (!wr_ready_o) begin
      timeouts++;
      $display("timeout: row %0d was never accepted by the row store", r);
    end
    @(posedge clk_i);
    #1 wr_valid_i = 1'b0;
  endtask

  task automatic load_matrix();
    for (int r = 0; r < `TI_SIZE; r++) begin
      write_row(r);
    end
  endtask

  task automatic pulse_start();
    @(posedge clk_i);
    #1 start_i = 1'b1;
    @(posedge clk_i);
    #1 start_i = 1'b0;
  endtask

  task automatic wait_busy(input logic level);
    int t;
    t = 0;
    @(negedge clk_i);
    while (busy_o !== level && t < BUSY_TMO) begin
      @(negedge clk_i);
      t++;
    end
    if (busy_o !== level) begin
      timeouts++;
      $display("timeout: busy_o did not go to %0d", level);
    end
  endtask

  task automatic receive_columns(input bit bp);
    cplx_t [`TI_SIZE-1:0] held;
    logic [`TI_AW-1:0]    held_idx;
    bit                   seen;
    bit                   taken;
    int                   t;
    for (int j = 0; j < `TI_SIZE; j++) begin
      seen  = 1'b0;
      taken = 1'b0;
      t     = 0;
      while (!taken && t < COL_TMO) begin
        @(posedge clk_i);
        #1 col_ready_i = bp ? ($urandom % 3 != 0) : 1'b1;
        @(negedge clk_i);
        t++;
        if (col_valid_o) begin
          // a waiting column must not move
          if (seen) begin
            check_val("col_idx_o held", 64'(held_idx), 64'(col_idx_o));
            for (int i = 0; i < `TI_SIZE; i++) begin
              check_val($sformatf("col_o[%0d] held", i), held[i], col_o[i]);
            end
          end
          held     = col_o;
          held_idx = col_idx_o;
          seen     = 1'b1;
          if (col_ready_i) begin
            taken = 1'b1;
            check_val("col_idx_o", 64'(j), 64'(col_idx_o));
            for (int i = 0; i < `TI_SIZE; i++) begin
              check_val($sformatf("col_o[%0d] of column %0d", i, j),
                        {x_im[i][j], x_re[i][j]}, col_o[i]);
            end
          end
        end
      end
      if (!taken) begin
        timeouts++;
        $display("timeout: column %0d never arrived", j);
      end
    end
    @(posedge clk_i);
    #1 col_ready_i = 1'b0;
  endtask

  task automatic run_inversion(input bit bp, input bit poke);
    pulse_start();
    wait_busy(1'b1);
    check_val("wr_ready_o", 64'(0), 64'(wr_ready_o));
    if (poke) begin
      // writes offered mid-run have to be refused
      repeat (3) begin
        @(posedge clk_i);
        #1;
        wr_valid_i = 1'b1;
        wr_addr_i  = `TI_AW'($urandom());
        for (int c = 0; c < `TI_SIZE; c++) begin
          wr_row_i[c] = {$urandom(), $urandom()};
        end
        @(negedge clk_i);
        check_val("wr_ready_o", 64'(0), 64'(wr_ready_o));
      end
      @(posedge clk_i);
      #1 wr_valid_i = 1'b0;
    end
    receive_columns(bp);
    wait_busy(1'b0);
  endtask

  task automatic flush_run();
    int delay;
    col_ready_i = 1'b0;
    pulse_start();
    delay = 1 + int'($urandom % 300);
    repeat (delay) @(posedge clk_i);
    #1 flush_i = 1'b1;
    @(posedge clk_i);
    #1 flush_i = 1'b0;
    @(negedge clk_i);
    check_val("busy_o after flush", 64'(0), 64'(busy_o));
    check_val("col_valid_o after flush", 64'(0), 64'(col_valid_o));
  endtask

  initial begin
    rst_ni      = 1'b0;
    wr_valid_i  = 1'b0;
    wr_addr_i   = '0;
    wr_row_i    = '0;
    start_i     = 1'b0;
    flush_i     = 1'b0;
    col_ready_i = 1'b0;
    void'($urandom(32));
    repeat (16) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    @(negedge clk_i);
    check_val("busy_o", 64'(0), 64'(busy_o));
    check_val("col_valid_o", 64'(0), 64'(col_valid_o));
    check_val("wr_ready_o", 64'(1), 64'(wr_ready_o));

    gen_matrix(1'b0);
    load_matrix();
    compute_inverse();
    run_inversion(1'b0, 1'b0);

    for (int n = 0; n < 10; n++) begin
      gen_matrix(1'b1);
      load_matrix();
      compute_inverse();
      run_inversion(1'b0, 1'b0);
    end

    for (int n = 0; n < 3; n++) begin
      gen_matrix(1'b1);
      load_matrix();
      compute_inverse();
      run_inversion(1'b1, 1'b0);
    end

    gen_matrix(1'b1);
    load_matrix();
    compute_inverse();
    run_inversion(1'b0, 1'b1);

    gen_matrix(1'b1);
    load_matrix();
    flush_run();
    gen_matrix(1'b1);
    load_matrix();
    compute_inverse();
    run_inversion(1'b1, 1'b0);

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- tri_inv.f
+incdir+.
tri_inv_pkg.sv
fxp_div.sv
cplx_recip.sv
cplx_mac.sv
row_store.sv
tri_matrix_inv.sv
tri_inv_top.sv
tb_tri_inv.sv

//--- tri_inv_defines.svh
`ifndef TRI_INV_DEFINES_SVH
`define TRI_INV_DEFINES_SVH

// matrix dimension
`define TI_SIZE 4

// fraction bits of one fixed-point part
`define TI_FRAC 16

// width of one real or imaginary part
`define TI_W 32

// row address width
`define TI_AW ($clog2(`TI_SIZE))

`endif

//--- tri_inv_pkg.sv
`include "tri_inv_defines.svh"

package tri_inv_pkg;

  // signed fixed point with TI_FRAC fraction bits
  typedef logic signed [`TI_W-1:0] fxp_t;

  // imaginary part high, real part low
  typedef struct packed {
    fxp_t im;
    fxp_t re;
  } cplx_t;

  typedef enum logic [2:0] {
    IDLE,
    FETCH_DIAG,
    DIAG,
    COL_ROW,
    COL_MAC,
    COL_SCALE,
    COL_OUT
  } inv_state_e;

  // the two passes through the shared divider
  typedef enum logic {
    DIV_RE,
    DIV_IM
  } recip_op_e;

endpackage

//--- tri_inv_top.sv
`timescale 1ns/1ps
`include "tri_inv_defines.svh"

module tri_inv_top import tri_inv_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 wr_valid_i,
  output logic                 wr_ready_o,
  input  logic [`TI_AW-1:0]    wr_addr_i,
  input  cplx_t [`TI_SIZE-1:0] wr_row_i,
  input  logic                 start_i,
  input  logic                 flush_i,
  output logic                 busy_o,
  output logic                 col_valid_o,
  input  logic                 col_ready_i,
  output logic [`TI_AW-1:0]    col_idx_o,
  output cplx_t [`TI_SIZE-1:0] col_o
);

  logic                 rd_valid;
  logic [`TI_AW-1:0]    rd_addr;
  logic                 rd_row_valid;
  cplx_t [`TI_SIZE-1:0] rd_row;

  row_store u_store (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .busy_i         (busy_o),
    .wr_valid_i     (wr_valid_i),
    .wr_ready_o     (wr_ready_o),
    .wr_addr_i      (wr_addr_i),
    .wr_row_i       (wr_row_i),
    .rd_valid_i     (rd_valid),
    .rd_addr_i      (rd_addr),
    .rd_row_valid_o (rd_row_valid),
    .rd_row_o       (rd_row)
  );

  tri_matrix_inv u_core (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (start_i),
    .flush_i        (flush_i),
    .busy_o         (busy_o),
    .rd_valid_o     (rd_valid),
    .rd_addr_o      (rd_addr),
    .rd_row_valid_i (rd_row_valid),
    .rd_row_i       (rd_row),
    .col_valid_o    (col_valid_o),
    .col_ready_i    (col_ready_i),
    .col_idx_o      (col_idx_o),
    .col_o          (col_o)
  );

endmodule

//--- tri_matrix_inv.sv
`timescale 1ns/1ps
`include "tri_inv_defines.svh"

module tri_matrix_inv import tri_inv_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  logic                 flush_i,
  output logic                 busy_o,
  output logic                 rd_valid_o,
  output logic [`TI_AW-1:0]    rd_addr_o,
  input  logic                 rd_row_valid_i,
  input  cplx_t [`TI_SIZE-1:0] rd_row_i,
  output logic                 col_valid_o,
  input  logic                 col_ready_i,
  output logic [`TI_AW-1:0]    col_idx_o,
  output cplx_t [`TI_SIZE-1:0] col_o
);

  localparam logic [`TI_AW-1:0] LAST = `TI_AW'(`TI_SIZE - 1);

  inv_state_e           state_q;
  logic [`TI_AW-1:0]    fptr_q;
  logic [`TI_AW-1:0]    wptr_q;
  logic [`TI_AW-1:0]    col_q;
  logic [`TI_AW-1:0]    row_i_q;
  logic [`TI_AW-1:0]    k_q;
  logic [`TI_AW-1:0]    next_col;
  logic                 row_ok_q;
  logic                 col_begin;
  cplx_t [`TI_SIZE-1:0] row_q;
  cplx_t [`TI_SIZE-1:0] xcol_q;
  cplx_t                rbuf_q [`TI_SIZE];
  logic                 rcp_in_valid;
  logic                 rcp_in_ready;
  logic                 rcp_out_valid;
  cplx_t                rcp_y;
  cplx_t                neg_scaled;
  logic                 mac_clr;
  logic                 mac_en;

  assign busy_o      = (state_q != IDLE);
  assign rd_valid_o  = (state_q == FETCH_DIAG) || (state_q == COL_ROW);
  assign rd_addr_o   = (state_q == FETCH_DIAG) ? fptr_q : row_i_q;
  assign col_valid_o = (state_q == COL_OUT);
  assign col_idx_o   = col_q;
  assign col_o       = xcol_q;

  assign rcp_in_valid = (state_q == DIAG) && row_ok_q;
  assign mac_clr      = (state_q == COL_ROW);
  assign mac_en       = (state_q == COL_MAC) && row_ok_q;

  // a column starts after the last reciprocal lands or a column is taken
  assign col_begin = ((state_q == DIAG) && rcp_out_valid && (wptr_q == LAST)) ||
                     ((state_q == COL_OUT) && col_ready_i && (col_q != LAST));
  assign next_col  = (state_q == COL_OUT) ? col_q + 1'b1 : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_ni || flush_i) begin
      state_q  <= IDLE;
      fptr_q   <= '0;
      wptr_q   <= '0;
      col_q    <= '0;
      row_i_q  <= '0;
      k_q      <= '0;
      row_ok_q <= 1'b0;
    end else begin
      if (rcp_out_valid) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (rd_row_valid_i && (state_q == DIAG || state_q == COL_MAC)) begin
        row_ok_q <= 1'b1;
      end
      case (state_q)
        IDLE: begin
          if (start_i) begin
            state_q  <= FETCH_DIAG;
            fptr_q   <= '0;
            wptr_q   <= '0;
            row_ok_q <= 1'b0;
          end
        end
        FETCH_DIAG: state_q <= DIAG;
        DIAG: begin
          // next row is requested while the division runs
          if (rcp_in_valid && rcp_in_ready) begin
            row_ok_q <= 1'b0;
            if (fptr_q != LAST) begin
              fptr_q  <= fptr_q + 1'b1;
              state_q <= FETCH_DIAG;
            end
          end
        end
        COL_ROW: begin
          k_q     <= col_q;
          state_q <= COL_MAC;
        end
        COL_MAC: begin
          if (row_ok_q) begin
            k_q <= k_q + 1'b1;
            if (k_q == row_i_q - 1'b1) begin
              row_ok_q <= 1'b0;
              state_q  <= COL_SCALE;
            end
          end
        end
        COL_SCALE: begin
          row_i_q <= row_i_q + 1'b1;
          state_q <= (row_i_q == LAST) ? COL_OUT : COL_ROW;
        end
        COL_OUT: begin
          if (col_ready_i && col_q == LAST) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
      if (col_begin) begin
        col_q   <= next_col;
        row_i_q <= next_col + 1'b1;
        state_q <= (next_col == LAST) ? COL_OUT : COL_ROW;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_row_valid_i) begin
      row_q <= rd_row_i;
    end
    if (rcp_out_valid) begin
      rbuf_q[wptr_q] <= rcp_y;
    end
    if (col_begin) begin
      // diagonal entry is the reciprocal, rows above stay zero
      for (int n = 0; n < `TI_SIZE; n++) begin
        if (n == next_col) begin
          xcol_q[n] <= rbuf_q[next_col];
        end else begin
          xcol_q[n] <= '0;
        end
      end
    end else if (state_q == COL_SCALE) begin
      xcol_q[row_i_q] <= neg_scaled;
    end
  end

  cplx_recip u_recip (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .in_valid_i  (rcp_in_valid),
    .in_ready_o  (rcp_in_ready),
    .x_i         (row_q[fptr_q]),
    .out_valid_o (rcp_out_valid),
    .out_ready_i (1'b1),
    .y_o         (rcp_y)
  );

  cplx_mac u_mac (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clr_i        (mac_clr),
    .acc_en_i     (mac_en),
    .a_i          (row_q[k_q]),
    .b_i          (xcol_q[k_q]),
    .scale_i      (rbuf_q[row_i_q]),
    .acc_o        (),
    .neg_scaled_o (neg_scaled)
  );

  // every fetch lands inside the row store and below the diagonal in the column stage
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_valid_o |-> (int'(rd_addr_o) < `TI_SIZE) &&
                   ((state_q == FETCH_DIAG) || (rd_addr_o > col_q)));

endmodule
